/* Makefile */
# Verilator build and run for the Ethernet loopback testbench.

VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tb_eth_loopback
RTL_TOP    ?= eth_loopback_top
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= All checks passed
RTL_FILES  ?= $(filter src/%,$(shell cat $(FLIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR)

/* bench/loopback_cases.txt */
# mode length_bytes bad_flag
# normal loops back, stall holds tx_ready_i low, reset gates the port during the frame
normal 64 0
normal 17 0
normal 40 1
normal 24 0
normal 72 0
normal 8 0
stall 32 0
stall 32 0
stall 32 0
stall 32 0
stall 32 0
stall 32 0
normal 56 0
reset 48 0
normal 33 0
reset 16 1
normal 64 0
normal 1 0

/* bench/tb_eth_loopback.sv */
// Self-checking testbench for the Ethernet loopback channel, driven from a case file.

`timescale 1ns/1ps

module tb_eth_loopback;

    localparam int MAX_FRAME_LEN = 64;
    localparam int FIFO_DEPTH    = 16;
    localparam int TX_GAP        = 2;
    localparam int RST_STAGES    = 4;
    localparam int WAIT_LIMIT    = 4000;

    logic                           clk_125mhz;
    logic                           rst_n_i;
    logic                           init_busy_i;
    logic                           pll_lol_n_i;
    logic                           rx_valid_i;
    eth_loopback_pkg::axis_beat_t   rx_beat_i;
    logic                           tx_ready_i;
    logic                           port_resetl_o;
    logic                           tx_valid_o;
    eth_loopback_pkg::axis_beat_t   tx_beat_o;
    eth_loopback_pkg::frame_stats_t stats_o;

    eth_loopback_pkg::axis_beat_t   exp_q[$];
    eth_loopback_pkg::axis_beat_t   mon_beat;
    eth_loopback_pkg::frame_stats_t exp_stats;
    int   data_seed;
    int   ready_seed;
    int   stall_beats;
    int   gap_left    = 0;
    int   value_errs  = 0;
    int   stat_errs   = 0;
    int   other_fails = 0;
    logic ready_hold;
    logic use_lol;

    eth_loopback_top #(
        .MAX_FRAME_LEN(MAX_FRAME_LEN),
        .FIFO_DEPTH(FIFO_DEPTH),
        .TX_GAP(TX_GAP),
        .RST_STAGES(RST_STAGES)
    ) u_dut (.*);

    initial begin
        clk_125mhz = 1'b0;
        forever #4 clk_125mhz = ~clk_125mhz;
    end

    // Ready is held low during a stall and random otherwise.
    initial begin
        ready_seed = 86287;
        tx_ready_i = 1'b0;
        forever begin
            @(negedge clk_125mhz);
            tx_ready_i = !ready_hold && ($random(ready_seed) % 2 != 0);
        end
    end

    task automatic check_beat(input eth_loopback_pkg::axis_beat_t got,
                              input eth_loopback_pkg::axis_beat_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: tx_beat_o got %h expected %h", $time, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_counter(input string name, input eth_loopback_pkg::stat_t got,
                                 input eth_loopback_pkg::stat_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: stats_o.%s got %0d expected %0d", $time, name, got, exp);
            stat_errs++;
        end
    endtask

    task automatic check_stats(input eth_loopback_pkg::frame_stats_t got,
                               input eth_loopback_pkg::frame_stats_t exp);
        check_counter("tx_good", got.tx_good, exp.tx_good);
        check_counter("drop_bad", got.drop_bad, exp.drop_bad);
        check_counter("drop_oversize", got.drop_oversize, exp.drop_oversize);
        check_counter("drop_full", got.drop_full, exp.drop_full);
    endtask

    // Every transmitted beat must match the head of the expected queue.
    always @(posedge clk_125mhz) begin
        if (rst_n_i) begin
            if (gap_left > 0) begin
                if (tx_valid_o) begin
                    $display("Error at %0t ns: tx_valid_o got 1 expected 0 in the gap", $time);
                    value_errs++;
                end
                gap_left--;
            end
            if (tx_valid_o && tx_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("At %0t ns the DUT sent a beat that no frame accounts for", $time);
                    other_fails++;
                end else begin
                    mon_beat = exp_q.pop_front();
                    check_beat(tx_beat_o, mon_beat);
                end
                if (tx_beat_o.last) begin
                    gap_left = TX_GAP;
                end
            end
        end
    end

    task automatic wait_port_level(input logic level);
        int cycles;
        cycles = 0;
        while (port_resetl_o !== level && cycles < WAIT_LIMIT) begin
            @(negedge clk_125mhz);
            cycles++;
        end
        if (port_resetl_o !== level) begin
            $display("Timeout at %0t ns: port_resetl_o never went to %0b", $time, level);
            other_fails++;
        end
    endtask

    // Wait for all expected beats and for the counters to settle.
    task automatic drain_and_check();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || stats_o !== exp_stats) && cycles < WAIT_LIMIT) begin
            @(negedge clk_125mhz);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout at %0t ns: %0d expected beats never came out", $time,
                     exp_q.size());
            other_fails++;
            exp_q.delete();
        end
        check_stats(stats_o, exp_stats);
        stall_beats = 0;
    endtask

    task automatic send_frame(input int len, input logic bad, input logic keep_it,
                              input logic in_reset);
        int nbeats;
        int bytes;
        eth_loopback_pkg::axis_beat_t beat;
        nbeats = (len + 7) / 8;
        for (int i = 0; i < nbeats; i++) begin
            @(negedge clk_125mhz);
            bytes = (len - 8 * i > 8) ? 8 : len - 8 * i;
            beat.data = {$random(data_seed), $random(data_seed)};
            // Unused byte lanes are cleared.
            for (int b = bytes; b < 8; b++) begin
                beat.data[8*b +: 8] = 8'h00;
            end
            beat.keep = 8'hff >> (8 - bytes);
            beat.last = (i == nbeats - 1);
            beat.user = bad && beat.last;
            rx_beat_i  = beat;
            rx_valid_i = 1'b1;
            if (keep_it) begin
                exp_q.push_back(beat);
            end
            if (in_reset && port_resetl_o !== 1'b0) begin
                $display("Error at %0t ns: port_resetl_o got %b expected 0", $time,
                         port_resetl_o);
                value_errs++;
            end
        end
        @(negedge clk_125mhz);
        rx_valid_i = 1'b0;
    endtask

    task automatic run_frame_case(input logic stall, input int len, input logic bad);
        int   nbeats;
        logic keep_it;
        nbeats  = (len + 7) / 8;
        keep_it = 1'b0;
        ready_hold = stall;
        if (!stall) begin
            drain_and_check();
        end
        // Bad wins over oversize, oversize over full.
        if (bad) begin
            exp_stats.drop_bad = exp_stats.drop_bad + 1;
        end else if (len > MAX_FRAME_LEN) begin
            exp_stats.drop_oversize = exp_stats.drop_oversize + 1;
        end else if (stall && stall_beats + nbeats > FIFO_DEPTH) begin
            exp_stats.drop_full = exp_stats.drop_full + 1;
        end else begin
            keep_it = 1'b1;
            exp_stats.tx_good = exp_stats.tx_good + 1;
            stall_beats = stall_beats + (stall ? nbeats : 0);
        end
        send_frame(len, bad, keep_it, 1'b0);
        if (!stall) begin
            drain_and_check();
        end
    endtask

    task automatic run_reset_case(input int len, input logic bad);
        ready_hold = 1'b0;
        drain_and_check();
        // Alternate between the two reset causes.
        if (use_lol) begin
            pll_lol_n_i = 1'b0;
        end else begin
            init_busy_i = 1'b1;
        end
        use_lol = !use_lol;
        wait_port_level(1'b0);
        send_frame(len, bad, 1'b0, 1'b1);
        init_busy_i = 1'b0;
        pll_lol_n_i = 1'b1;
        wait_port_level(1'b1);
        // Datapath reset drops RST_STAGES cycles after the cause.
        repeat (RST_STAGES) @(negedge clk_125mhz);
        drain_and_check();
    endtask

    initial begin
        int               fd;
        int               n;
        int               len;
        int               bad;
        logic [8*8-1:0]   tok;
        logic [8*128-1:0] line;
        data_seed   = 86287;
        rst_n_i     = 1'b0;
        init_busy_i = 1'b0;
        pll_lol_n_i = 1'b1;
        rx_valid_i  = 1'b0;
        rx_beat_i   = '0;
        ready_hold  = 1'b1;
        use_lol     = 1'b0;
        stall_beats = 0;
        exp_stats   = '0;
        repeat (5) @(negedge clk_125mhz);
        if (tx_valid_o !== 1'b0) begin
            $display("Error at %0t ns: tx_valid_o got %b expected 0", $time, tx_valid_o);
            value_errs++;
        end
        if (port_resetl_o !== 1'b0) begin
            $display("Error at %0t ns: port_resetl_o got %b expected 0", $time,
                     port_resetl_o);
            value_errs++;
        end
        check_stats(stats_o, exp_stats);
        rst_n_i = 1'b1;
        wait_port_level(1'b1);
        repeat (RST_STAGES) @(negedge clk_125mhz);
        fd = $fopen("bench/loopback_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file bench/loopback_cases.txt");
            other_fails++;
        end else begin
            n = $fscanf(fd, "%s", tok);
            while (n == 1) begin
                if (tok == "#") begin
                    n = $fgets(line, fd);
                end else begin
                    n = $fscanf(fd, "%d %d", len, bad);
                    if (n != 2) begin
                        $display("A case line could not be read after mode %0s", tok);
                        other_fails++;
                    end else if (tok == "normal") begin
                        run_frame_case(1'b0, len, bad != 0);
                    end else if (tok == "stall") begin
                        run_frame_case(1'b1, len, bad != 0);
                    end else if (tok == "reset") begin
                        run_reset_case(len, bad != 0);
                    end else begin
                        $display("The case file has an unknown mode %0s", tok);
                        other_fails++;
                    end
                end
                n = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
        ready_hold = 1'b0;
        drain_and_check();
        $display("Errors: %0d value, %0d stats, %0d other", value_errs, stat_errs,
                 other_fails);
        if (value_errs + stat_errs + other_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* flist.f */
src/eth_loopback_pkg.sv
src/port_reset_ctrl.sv
src/rx_frame_filter.sv
src/frame_fifo.sv
src/tx_frame_sender.sv
src/frame_stats.sv
src/eth_loopback_top.sv
bench/tb_eth_loopback.sv

/* src/eth_loopback_pkg.sv */
// Shared beat, statistics and width definitions for the Ethernet loopback channel.

package eth_loopback_pkg;

    // Stream widths.
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    // One stream beat. The user bit marks a bad frame.
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic              user;
    } axis_beat_t;

    // Counter width.
    localparam int STAT_W = 32;

    typedef logic [STAT_W-1:0] stat_t;

    // Frame counters.
    typedef struct packed {
        stat_t tx_good;
        stat_t drop_bad;
        stat_t drop_oversize;
        stat_t drop_full;
    } frame_stats_t;

    // Single-cycle drop pulses, one per reason.
    typedef struct packed {
        logic bad;
        logic oversize;
        logic full;
    } drop_event_t;

endpackage

/* src/eth_loopback_top.sv */
// Single-port Ethernet loopback through a frame FIFO, with reset gating and statistics.

`timescale 1ns/1ps

module eth_loopback_top #(
    parameter int MAX_FRAME_LEN = 9218,
    parameter int FIFO_DEPTH    = 512,
    parameter int TX_GAP        = 1,
    parameter int RST_STAGES    = 4
) (
    input  logic                           clk_125mhz,
    input  logic                           rst_n_i,
    input  logic                           init_busy_i,
    input  logic                           pll_lol_n_i,
    input  logic                           rx_valid_i,
    input  eth_loopback_pkg::axis_beat_t   rx_beat_i,
    input  logic                           tx_ready_i,
    output logic                           port_resetl_o,
    output logic                           tx_valid_o,
    output eth_loopback_pkg::axis_beat_t   tx_beat_o,
    output eth_loopback_pkg::frame_stats_t stats_o
);

    logic                          eth_rst;
    logic                          filt_valid;
    eth_loopback_pkg::axis_beat_t  filt_beat;
    logic                          filt_oversize;
    logic                          rd_valid;
    eth_loopback_pkg::axis_beat_t  rd_beat;
    logic                          rd_take;
    eth_loopback_pkg::drop_event_t drop;
    logic                          tx_done;

    port_reset_ctrl #(.RST_STAGES(RST_STAGES)) u_reset (
        .clk_125mhz(clk_125mhz), .rst_n_i(rst_n_i), .init_busy_i(init_busy_i),
        .pll_lol_n_i(pll_lol_n_i), .port_resetl_o(port_resetl_o), .eth_rst_o(eth_rst));

    rx_frame_filter #(.MAX_FRAME_LEN(MAX_FRAME_LEN)) u_rx_filter (
        .clk_125mhz(clk_125mhz), .rst_n_i(rst_n_i), .eth_rst_i(eth_rst),
        .rx_valid_i(rx_valid_i), .rx_beat_i(rx_beat_i), .filt_valid_o(filt_valid),
        .filt_beat_o(filt_beat), .filt_oversize_o(filt_oversize));

    frame_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk_125mhz(clk_125mhz), .rst_n_i(rst_n_i), .eth_rst_i(eth_rst),
        .filt_valid_i(filt_valid), .filt_beat_i(filt_beat), .filt_oversize_i(filt_oversize),
        .rd_take_i(rd_take), .rd_valid_o(rd_valid), .rd_beat_o(rd_beat), .drop_o(drop));

    tx_frame_sender #(.TX_GAP(TX_GAP)) u_tx_sender (
        .clk_125mhz(clk_125mhz), .rst_n_i(rst_n_i), .eth_rst_i(eth_rst),
        .rd_valid_i(rd_valid), .rd_beat_i(rd_beat), .tx_ready_i(tx_ready_i),
        .rd_take_o(rd_take), .tx_valid_o(tx_valid_o), .tx_beat_o(tx_beat_o),
        .tx_done_o(tx_done));

    frame_stats u_stats (
        .clk_125mhz(clk_125mhz), .rst_n_i(rst_n_i), .drop_i(drop),
        .tx_done_i(tx_done), .stats_o(stats_o));

endmodule

/* src/frame_fifo.sv */
// Frame FIFO that commits whole good frames and drops bad, oversize and overflowing ones.

`timescale 1ns/1ps

module frame_fifo #(
    parameter int FIFO_DEPTH = 512
) (
    input  logic                          clk_125mhz,
    input  logic                          rst_n_i,
    input  logic                          eth_rst_i,
    input  logic                          filt_valid_i,
    input  eth_loopback_pkg::axis_beat_t  filt_beat_i,
    input  logic                          filt_oversize_i,
    input  logic                          rd_take_i,
    output logic                          rd_valid_o,
    output eth_loopback_pkg::axis_beat_t  rd_beat_o,
    output eth_loopback_pkg::drop_event_t drop_o
);

    localparam int AW    = $clog2(FIFO_DEPTH);
    localparam int PTR_W = AW + 1;

    eth_loopback_pkg::axis_beat_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] commit_ptr_q;
    logic [PTR_W-1:0] commit_rd_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] fill;
    logic             full;
    logic             drop_q;
    logic             wr_en;

    assign fill  = wr_ptr_q - rd_ptr_q;
    assign full  = (fill == PTR_W'(FIFO_DEPTH));
    // Once a frame overflows, the rest of it is skipped.
    assign wr_en = filt_valid_i && !drop_q && !full;

    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q     <= '0;
            commit_ptr_q <= '0;
            commit_rd_q  <= '0;
            rd_ptr_q     <= '0;
            drop_q       <= 1'b0;
            drop_o       <= '0;
        end else if (eth_rst_i) begin
            wr_ptr_q     <= '0;
            commit_ptr_q <= '0;
            commit_rd_q  <= '0;
            rd_ptr_q     <= '0;
            drop_q       <= 1'b0;
            drop_o       <= '0;
        end else begin
            drop_o      <= '0;
            // Read side sees a commit one cycle late.
            commit_rd_q <= commit_ptr_q;
            if (rd_take_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (filt_valid_i) begin
                if (wr_en) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end else begin
                    drop_q <= 1'b1;
                end
                if (filt_beat_i.last) begin
                    drop_q <= 1'b0;
                    if (filt_beat_i.user) begin
                        drop_o.bad <= 1'b1;
                        wr_ptr_q   <= commit_ptr_q;
                    end else if (filt_oversize_i) begin
                        drop_o.oversize <= 1'b1;
                        wr_ptr_q        <= commit_ptr_q;
                    end else if (!wr_en) begin
                        drop_o.full <= 1'b1;
                        wr_ptr_q    <= commit_ptr_q;
                    end else begin
                        commit_ptr_q <= wr_ptr_q + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr_q[AW-1:0]] <= filt_beat_i;
        end
    end

    assign rd_valid_o = (commit_rd_q != rd_ptr_q);
    assign rd_beat_o  = mem[rd_ptr_q[AW-1:0]];

    // The sender only takes committed beats.
    a_no_read_empty: assert property (@(posedge clk_125mhz) disable iff (!rst_n_i)
        rd_take_i |-> rd_valid_o);

    a_one_drop: assert property (@(posedge clk_125mhz) disable iff (!rst_n_i)
        $onehot0(drop_o));

endmodule

/* src/frame_stats.sv */
// Saturating counters for sent frames and for each kind of dropped frame.

`timescale 1ns/1ps

module frame_stats (
    input  logic                          clk_125mhz,
    input  logic                          rst_n_i,
    input  eth_loopback_pkg::drop_event_t drop_i,
    input  logic                          tx_done_i,
    output eth_loopback_pkg::frame_stats_t stats_o
);

    // Step a counter by one, stopping at the top.
    function automatic eth_loopback_pkg::stat_t sat_inc(
        input eth_loopback_pkg::stat_t cnt,
        input logic                    ev
    );
        eth_loopback_pkg::stat_t res;
        res = cnt;
        if (ev && (cnt != '1)) begin
            res = cnt + 1'b1;
        end
        return res;
    endfunction

    // Port resets leave the counts alone.
    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stats_o <= '0;
        end else begin
            stats_o.tx_good       <= sat_inc(stats_o.tx_good, tx_done_i);
            stats_o.drop_bad      <= sat_inc(stats_o.drop_bad, drop_i.bad);
            stats_o.drop_oversize <= sat_inc(stats_o.drop_oversize, drop_i.oversize);
            stats_o.drop_full     <= sat_inc(stats_o.drop_full, drop_i.full);
        end
    end

endmodule

/* src/port_reset_ctrl.sv */
// Port reset gating from clock init and PLL lock, with a synchronized datapath reset.

`timescale 1ns/1ps

module port_reset_ctrl #(
    parameter int RST_STAGES = 4
) (
    input  logic clk_125mhz,
    input  logic rst_n_i,
    input  logic init_busy_i,
    input  logic pll_lol_n_i,
    output logic port_resetl_o,
    output logic eth_rst_o
);

    logic                  reset_cause;
    logic                  port_reset_q;
    logic [RST_STAGES-1:0] rst_sync_q;

    // Hold ports while the synthesizer is busy or unlocked.
    assign reset_cause = init_busy_i || !pll_lol_n_i;

    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            port_reset_q <= 1'b1;
            rst_sync_q   <= '1;
        end else begin
            port_reset_q <= reset_cause;
            // Assert at once, release through the stage chain.
            if (reset_cause) begin
                rst_sync_q <= '1;
            end else begin
                rst_sync_q <= {rst_sync_q[RST_STAGES-2:0], 1'b0};
            end
        end
    end

    assign port_resetl_o = !port_reset_q;
    assign eth_rst_o     = rst_sync_q[RST_STAGES-1];

    // Datapath stays in reset for as long as the port does.
    a_rst_covers_port: assert property (@(posedge clk_125mhz) disable iff (!rst_n_i)
        !port_resetl_o |-> eth_rst_o);

endmodule

/* src/rx_frame_filter.sv */
// Receive stage that registers beats and flags frames longer than the size limit.

`timescale 1ns/1ps

module rx_frame_filter #(
    parameter int MAX_FRAME_LEN = 9218
) (
    input  logic                         clk_125mhz,
    input  logic                         rst_n_i,
    input  logic                         eth_rst_i,
    input  logic                         rx_valid_i,
    input  eth_loopback_pkg::axis_beat_t rx_beat_i,
    output logic                         filt_valid_o,
    output eth_loopback_pkg::axis_beat_t filt_beat_o,
    output logic                         filt_oversize_o
);

    localparam int KEEP_W       = eth_loopback_pkg::KEEP_W;
    localparam int BEAT_BYTES_W = $clog2(KEEP_W + 1);
    localparam int CNT_W        = $clog2(MAX_FRAME_LEN + KEEP_W + 1);

    logic [BEAT_BYTES_W-1:0] beat_bytes;
    logic [CNT_W-1:0]        byte_cnt_q;
    logic [CNT_W-1:0]        next_cnt;
    logic                    over_q;
    logic                    over_now;

    // Bytes enabled in one beat.
    function automatic logic [BEAT_BYTES_W-1:0] count_bytes(input logic [KEEP_W-1:0] keep);
        logic [BEAT_BYTES_W-1:0] n;
        n = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            n = n + BEAT_BYTES_W'(keep[i]);
        end
        return n;
    endfunction

    assign beat_bytes = count_bytes(rx_beat_i.keep);
    assign next_cnt   = byte_cnt_q + CNT_W'(beat_bytes);
    assign over_now   = over_q || (next_cnt > CNT_W'(MAX_FRAME_LEN));

    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            byte_cnt_q      <= '0;
            over_q          <= 1'b0;
            filt_valid_o    <= 1'b0;
            filt_oversize_o <= 1'b0;
        end else if (eth_rst_i) begin
            byte_cnt_q      <= '0;
            over_q          <= 1'b0;
            filt_valid_o    <= 1'b0;
            filt_oversize_o <= 1'b0;
        end else begin
            filt_valid_o <= rx_valid_i;
            if (rx_valid_i) begin
                filt_oversize_o <= over_now;
                if (rx_beat_i.last) begin
                    byte_cnt_q <= '0;
                    over_q     <= 1'b0;
                end else begin
                    // Count freezes once the limit is passed.
                    byte_cnt_q <= over_now ? byte_cnt_q : next_cnt;
                    over_q     <= over_now;
                end
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        filt_beat_o <= rx_beat_i;
    end

endmodule

/* src/tx_frame_sender.sv */
// Transmit stage that streams committed beats and enforces the inter-frame gap.

`timescale 1ns/1ps

module tx_frame_sender #(
    parameter int TX_GAP = 1
) (
    input  logic                         clk_125mhz,
    input  logic                         rst_n_i,
    input  logic                         eth_rst_i,
    input  logic                         rd_valid_i,
    input  eth_loopback_pkg::axis_beat_t rd_beat_i,
    input  logic                         tx_ready_i,
    output logic                         rd_take_o,
    output logic                         tx_valid_o,
    output eth_loopback_pkg::axis_beat_t tx_beat_o,
    output logic                         tx_done_o
);

    localparam int GAP_W = $clog2(TX_GAP + 2);

    logic [GAP_W-1:0] gap_cnt_q;
    logic             slot_free;

    // A new beat may follow a non-last beat directly.
    assign slot_free = !tx_valid_o || (tx_ready_i && !tx_beat_o.last);
    assign rd_take_o = rd_valid_i && slot_free && (gap_cnt_q <= 1) && !eth_rst_i;
    assign tx_done_o = tx_valid_o && tx_ready_i && tx_beat_o.last;

    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_valid_o <= 1'b0;
            gap_cnt_q  <= '0;
        end else if (eth_rst_i) begin
            tx_valid_o <= 1'b0;
            gap_cnt_q  <= '0;
        end else begin
            if (gap_cnt_q != '0) begin
                gap_cnt_q <= gap_cnt_q - 1'b1;
            end
            if (tx_done_o) begin
                tx_valid_o <= 1'b0;
                gap_cnt_q  <= GAP_W'(TX_GAP);
            end else if (rd_take_o) begin
                tx_valid_o <= 1'b1;
            end else if (tx_ready_i) begin
                tx_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rd_take_o) begin
            tx_beat_o <= rd_beat_i;
        end
    end

    a_stall_stable: assert property (@(posedge clk_125mhz)
        disable iff (!rst_n_i || eth_rst_i)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_beat_o));

endmodule
